// File: project.f
source/adc_types_pkg.sv
source/adc_config_pkg.sv
source/adc_control_unit.sv
source/threshold_comparator.sv
source/sample_decimator.sv
source/sample_calibration.sv
source/adc_processing.sv
verification/clock_gen.sv
verification/adc_processing_sva.sv
verification/adc_processing_tb.sv

// File: source/adc_config_pkg.sv
// Configuration types for the ADC processing chain
// Register writes, address map, thresholds, coefficients and control word
package adc_config_pkg;

    import adc_types_pkg::*;

    typedef logic [3:0] reg_address_t;

    // Gain is signed Q4.12
    typedef logic signed [15:0] gain_t;
    localparam int GAIN_FRACTION_BITS = 12;

    // 0 and 1 both mean that every sample passes
    typedef logic [4:0] decimation_ratio_t;

    typedef struct packed {
        logic         enable;
        reg_address_t address;
        sample_t      data;
    } reg_write_t;

    typedef struct packed {
        sample_t high_trip;
        sample_t high_release;
        sample_t low_trip;
        sample_t low_release;
    } threshold_set_t;

    typedef struct packed {
        sample_t offset;
        gain_t   gain;
        sample_t limit;
    } calibration_coefficients_t;

    typedef struct packed {
        logic              gain_enable;
        logic              fast_latching;
        logic              slow_latching;
        decimation_ratio_t decimation_ratio;
    } control_word_t;

    // Register map
    localparam reg_address_t ADDR_FAST_HIGH_TRIP    = 4'd0;
    localparam reg_address_t ADDR_FAST_HIGH_RELEASE = 4'd1;
    localparam reg_address_t ADDR_FAST_LOW_TRIP     = 4'd2;
    localparam reg_address_t ADDR_FAST_LOW_RELEASE  = 4'd3;
    localparam reg_address_t ADDR_SLOW_HIGH_TRIP    = 4'd4;
    localparam reg_address_t ADDR_SLOW_HIGH_RELEASE = 4'd5;
    localparam reg_address_t ADDR_SLOW_LOW_TRIP     = 4'd6;
    localparam reg_address_t ADDR_SLOW_LOW_RELEASE  = 4'd7;
    localparam reg_address_t ADDR_OFFSET            = 4'd8;
    localparam reg_address_t ADDR_GAIN              = 4'd9;
    localparam reg_address_t ADDR_LIMIT             = 4'd10;
    localparam reg_address_t ADDR_CONTROL           = 4'd11;
    localparam reg_address_t ADDR_CLEAR             = 4'd12;
    localparam reg_address_t ADDR_FLUSH             = 4'd13;

    // Bit positions inside the control and clear words
    localparam int CTRL_GAIN_ENABLE_BIT   = 0;
    localparam int CTRL_FAST_LATCHING_BIT = 1;
    localparam int CTRL_SLOW_LATCHING_BIT = 2;
    localparam int CTRL_RATIO_LSB         = 8;
    localparam int CLEAR_FAST_BIT         = 0;
    localparam int CLEAR_SLOW_BIT         = 1;
    localparam int CLEAR_FAULT_BIT        = 2;

endpackage

// File: source/adc_control_unit.sv
// Control unit of the ADC chain
// Register file, clear and flush pulses, fault combiner
`timescale 1ns/1ns

module adc_control_unit #(
    parameter int STICKY_FAULT = 1
) (
    input  logic                                  clock,
    input  logic                                  reset,
    input  adc_config_pkg::reg_write_t            config_write,
    input  adc_types_pkg::trip_flags_t            trip,
    output adc_config_pkg::threshold_set_t        fast_thresholds,
    output adc_config_pkg::threshold_set_t        slow_thresholds,
    output adc_config_pkg::calibration_coefficients_t coefficients,
    output adc_config_pkg::control_word_t         control,
    output logic                                  clear_fast,
    output logic                                  clear_slow,
    output logic                                  flush,
    output logic                                  fault
);

    import adc_config_pkg::*;

    logic clear_fault;
    logic trip_active;
    logic clear_write;

    assign clear_write = config_write.enable && (config_write.address == ADDR_CLEAR);
    assign trip_active = |trip;

    // Register file, loaded by the write strobe
    always_ff @(posedge clock) begin
        if (reset) begin
            fast_thresholds <= '0;
            slow_thresholds <= '0;
            coefficients    <= '0;
            control         <= '0;
        end else if (config_write.enable) begin
            case (config_write.address)
                ADDR_FAST_HIGH_TRIP:    fast_thresholds.high_trip    <= config_write.data;
                ADDR_FAST_HIGH_RELEASE: fast_thresholds.high_release <= config_write.data;
                ADDR_FAST_LOW_TRIP:     fast_thresholds.low_trip     <= config_write.data;
                ADDR_FAST_LOW_RELEASE:  fast_thresholds.low_release  <= config_write.data;
                ADDR_SLOW_HIGH_TRIP:    slow_thresholds.high_trip    <= config_write.data;
                ADDR_SLOW_HIGH_RELEASE: slow_thresholds.high_release <= config_write.data;
                ADDR_SLOW_LOW_TRIP:     slow_thresholds.low_trip     <= config_write.data;
                ADDR_SLOW_LOW_RELEASE:  slow_thresholds.low_release  <= config_write.data;
                ADDR_OFFSET:            coefficients.offset          <= config_write.data;
                ADDR_GAIN:              coefficients.gain            <= config_write.data;
                ADDR_LIMIT:             coefficients.limit           <= config_write.data;
                ADDR_CONTROL: begin
                    control.gain_enable      <= config_write.data[CTRL_GAIN_ENABLE_BIT];
                    control.fast_latching    <= config_write.data[CTRL_FAST_LATCHING_BIT];
                    control.slow_latching    <= config_write.data[CTRL_SLOW_LATCHING_BIT];
                    control.decimation_ratio <=
                        config_write.data[CTRL_RATIO_LSB +: $bits(decimation_ratio_t)];
                end
                // Clear and flush only make pulses, unused addresses fall through
                default: ;
            endcase
        end
    end

    // Command pulses are high for one cycle after the write
    always_ff @(posedge clock) begin
        if (reset) begin
            clear_fast  <= 1'b0;
            clear_slow  <= 1'b0;
            clear_fault <= 1'b0;
            flush       <= 1'b0;
        end else begin
            clear_fast  <= clear_write && config_write.data[CLEAR_FAST_BIT];
            clear_slow  <= clear_write && config_write.data[CLEAR_SLOW_BIT];
            clear_fault <= clear_write && config_write.data[CLEAR_FAULT_BIT];
            flush       <= config_write.enable && (config_write.address == ADDR_FLUSH);
        end
    end

    // Fault is the registered OR of the trip flags
    // In sticky mode the clear pulse wins for one cycle, which lets a latch
    // cleared by the same write drop out before the OR is sampled again
    always_ff @(posedge clock) begin
        if (reset) begin
            fault <= 1'b0;
        end else if (STICKY_FAULT != 0) begin
            if (clear_fault) begin
                fault <= 1'b0;
            end else begin
                fault <= fault || trip_active;
            end
        end else begin
            fault <= trip_active;
        end
    end

endmodule

// File: source/adc_processing.sv
// Top level of the ADC processing chain
// Control unit, fast and slow comparators, decimator and calibration
`timescale 1ns/1ns

module adc_processing #(
    parameter int MAX_DECIMATION_RATIO = 16,
    parameter int STICKY_FAULT         = 1
) (
    input  logic                          clock,
    input  logic                          reset,
    input  adc_types_pkg::sample_stream_t sample_in,
    input  adc_config_pkg::reg_write_t    config_write,
    output adc_types_pkg::sample_stream_t sample_out,
    output adc_types_pkg::trip_flags_t    trip,
    output logic                          fault
);

    import adc_types_pkg::*;
    import adc_config_pkg::*;

    threshold_set_t            fast_thresholds;
    threshold_set_t            slow_thresholds;
    calibration_coefficients_t coefficients;
    control_word_t             control;
    logic                      clear_fast;
    logic                      clear_slow;
    logic                      flush;
    sample_stream_t            decimated;
    comparator_trip_t          fast_trip;
    comparator_trip_t          slow_trip;

    adc_control_unit #(
        .STICKY_FAULT(STICKY_FAULT)
    ) control_unit (
        .clock(clock),
        .reset(reset),
        .config_write(config_write),
        .trip(trip),
        .fast_thresholds(fast_thresholds),
        .slow_thresholds(slow_thresholds),
        .coefficients(coefficients),
        .control(control),
        .clear_fast(clear_fast),
        .clear_slow(clear_slow),
        .flush(flush),
        .fault(fault)
    );

    // Fast comparator sees every raw sample
    threshold_comparator fast_comparator (
        .clock(clock),
        .reset(reset),
        .samples(sample_in),
        .thresholds(fast_thresholds),
        .latching(control.fast_latching),
        .clear_latch(clear_fast),
        .trip(fast_trip)
    );

    // The decimator produces the slow stream
    sample_decimator #(
        .MAX_DECIMATION_RATIO(MAX_DECIMATION_RATIO)
    ) decimator (
        .clock(clock),
        .reset(reset),
        .ratio(control.decimation_ratio),
        .samples(sample_in),
        .decimated(decimated)
    );

    threshold_comparator slow_comparator (
        .clock(clock),
        .reset(reset),
        .samples(decimated),
        .thresholds(slow_thresholds),
        .latching(control.slow_latching),
        .clear_latch(clear_slow),
        .trip(slow_trip)
    );

    sample_calibration calibration (
        .clock(clock),
        .reset(reset),
        .samples(decimated),
        .coefficients(coefficients),
        .gain_enable(control.gain_enable),
        .flush(flush),
        .calibrated(sample_out)
    );

    assign trip = '{
        fast_high: fast_trip.high,
        fast_low:  fast_trip.low,
        slow_high: slow_trip.high,
        slow_low:  slow_trip.low
    };

endmodule

// File: source/adc_types_pkg.sv
// Data path types for the ADC processing chain
// Samples, sample streams and comparator trip flags
package adc_types_pkg;

    // Raw ADC samples are signed two's complement
    localparam int SAMPLE_WIDTH = 16;

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    // Saturation bounds of the sample range
    localparam sample_t SAMPLE_MAX = sample_t'(16'sh7fff);
    localparam sample_t SAMPLE_MIN = sample_t'(16'sh8000);

    // One sample with its single-cycle valid strobe
    typedef struct packed {
        sample_t data;
        logic    valid;
    } sample_stream_t;

    // Output of a single comparator
    typedef struct packed {
        logic high;
        logic low;
    } comparator_trip_t;

    // All four trip flags of the chain, fast side first
    typedef struct packed {
        logic fast_high;
        logic fast_low;
        logic slow_high;
        logic slow_low;
    } trip_flags_t;

endpackage

// File: source/sample_calibration.sv
// Two-stage calibration pipeline
// Offset removal, optional Q4.12 gain, clamp to limit and sample range
`timescale 1ns/1ns

module sample_calibration (
    input  logic                                      clock,
    input  logic                                      reset,
    input  adc_types_pkg::sample_stream_t             samples,
    input  adc_config_pkg::calibration_coefficients_t coefficients,
    input  logic                                      gain_enable,
    input  logic                                      flush,
    output adc_types_pkg::sample_stream_t             calibrated
);

    import adc_types_pkg::*;
    import adc_config_pkg::*;

    // One extra bit keeps the offset subtraction exact
    typedef logic signed [$bits(sample_t):0] difference_t;
    typedef logic signed [$bits(difference_t)+$bits(gain_t)-1:0] product_t;

    difference_t stage1_diff;
    logic        stage1_valid;
    product_t    product;
    product_t    scaled;
    product_t    limit_high;
    product_t    limit_low;
    product_t    clamped;
    sample_t     out_data;
    logic        out_valid;

    // Valid bits, both dropped by a flush
    always_ff @(posedge clock) begin
        if (reset) begin
            stage1_valid <= 1'b0;
            out_valid    <= 1'b0;
        end else if (flush) begin
            stage1_valid <= 1'b0;
            out_valid    <= 1'b0;
        end else begin
            stage1_valid <= samples.valid;
            out_valid    <= stage1_valid;
        end
    end

    // Stage 1 removes the offset
    always_ff @(posedge clock) begin
        if (samples.valid) begin
            stage1_diff <= difference_t'(samples.data) - difference_t'(coefficients.offset);
        end
    end

    assign product = stage1_diff * coefficients.gain;

    // Stage 2 scales, then clamps to the limit and to the sample range
    always_comb begin
        if (gain_enable) begin
            scaled = product >>> GAIN_FRACTION_BITS;
        end else begin
            scaled = product_t'(stage1_diff);
        end
        limit_high = product_t'(coefficients.limit);
        limit_low  = -limit_high;
        clamped    = scaled;
        if (clamped > limit_high) begin
            clamped = limit_high;
        end else if (clamped < limit_low) begin
            clamped = limit_low;
        end
        if (clamped > product_t'(SAMPLE_MAX)) begin
            clamped = product_t'(SAMPLE_MAX);
        end else if (clamped < product_t'(SAMPLE_MIN)) begin
            clamped = product_t'(SAMPLE_MIN);
        end
    end

    always_ff @(posedge clock) begin
        if (stage1_valid) begin
            out_data <= sample_t'(clamped);
        end
    end

    assign calibrated = '{data: out_data, valid: out_valid};

endmodule

// File: source/sample_decimator.sv
// Keep-one-in-N decimator for the sample stream
`timescale 1ns/1ns

module sample_decimator #(
    parameter int MAX_DECIMATION_RATIO = 16
) (
    input  logic                              clock,
    input  logic                              reset,
    input  adc_config_pkg::decimation_ratio_t ratio,
    input  adc_types_pkg::sample_stream_t     samples,
    output adc_types_pkg::sample_stream_t     decimated
);

    import adc_types_pkg::*;
    import adc_config_pkg::*;

    decimation_ratio_t effective_ratio;
    decimation_ratio_t previous_ratio;
    decimation_ratio_t count;
    decimation_ratio_t count_base;
    decimation_ratio_t count_next;
    logic              ratio_changed;
    logic              group_done;
    logic              out_valid;
    sample_t           out_data;

    // Ratios of 0 and 1 pass everything, large ratios saturate
    always_comb begin
        if (ratio <= decimation_ratio_t'(1)) begin
            effective_ratio = decimation_ratio_t'(1);
        end else if (ratio > decimation_ratio_t'(MAX_DECIMATION_RATIO)) begin
            effective_ratio = decimation_ratio_t'(MAX_DECIMATION_RATIO);
        end else begin
            effective_ratio = ratio;
        end
    end

    // A new ratio starts a fresh group, counting a sample in the same cycle
    assign ratio_changed = ratio != previous_ratio;
    assign count_base    = ratio_changed ? '0 : count;
    assign count_next    = count_base + decimation_ratio_t'(1);
    assign group_done    = samples.valid && (count_next >= effective_ratio);

    always_ff @(posedge clock) begin
        if (reset) begin
            count          <= '0;
            previous_ratio <= '0;
            out_valid      <= 1'b0;
        end else begin
            previous_ratio <= ratio;
            out_valid      <= group_done;
            if (group_done) begin
                count <= '0;
            end else if (samples.valid) begin
                count <= count_next;
            end else begin
                count <= count_base;
            end
        end
    end

    // Last sample of each group
    always_ff @(posedge clock) begin
        if (group_done) begin
            out_data <= samples.data;
        end
    end

    assign decimated = '{data: out_data, valid: out_valid};

endmodule

// File: source/threshold_comparator.sv
// Hysteresis comparator with high and low trip flags
// Optional latching of set flags until an explicit clear
`timescale 1ns/1ns

module threshold_comparator (
    input  logic                           clock,
    input  logic                           reset,
    input  adc_types_pkg::sample_stream_t  samples,
    input  adc_config_pkg::threshold_set_t thresholds,
    input  logic                           latching,
    input  logic                           clear_latch,
    output adc_types_pkg::comparator_trip_t trip
);

    logic above_high_trip;
    logic below_high_release;
    logic below_low_trip;
    logic above_low_release;
    logic latch_cleared;

    // Thresholds and samples are both signed
    assign above_high_trip    = samples.data > thresholds.high_trip;
    assign below_high_release = samples.data < thresholds.high_release;
    assign below_low_trip     = samples.data < thresholds.low_trip;
    assign above_low_release  = samples.data > thresholds.low_release;

    // Clear only matters while latching, and then it beats a new trip
    assign latch_cleared = latching && clear_latch;

    // High side
    always_ff @(posedge clock) begin
        if (reset) begin
            trip.high <= 1'b0;
        end else if (latch_cleared) begin
            trip.high <= 1'b0;
        end else if (samples.valid) begin
            if (above_high_trip) begin
                trip.high <= 1'b1;
            end else if (!latching && below_high_release) begin
                trip.high <= 1'b0;
            end
        end
    end

    // Low side mirrors the high side
    always_ff @(posedge clock) begin
        if (reset) begin
            trip.low <= 1'b0;
        end else if (latch_cleared) begin
            trip.low <= 1'b0;
        end else if (samples.valid) begin
            if (below_low_trip) begin
                trip.low <= 1'b1;
            end else if (!latching && above_low_release) begin
                trip.low <= 1'b0;
            end
        end
    end

endmodule

// File: verification/adc_processing_sva.sv
// Assertions for the ADC processing top level
// Reset state of fault, output valid origin, sticky fault hold and a failure count
`timescale 1ns/1ns

module adc_processing_sva #(
    parameter int STICKY_FAULT = 1
) (
    input logic                          clock,
    input logic                          reset,
    input adc_config_pkg::reg_write_t    config_write,
    input adc_types_pkg::sample_stream_t sample_out,
    input adc_types_pkg::sample_stream_t decimated,
    input logic                          fault
);

    import adc_config_pkg::*;

    logic fault_clear_write;
    int   failure_count = 0;

    assign fault_clear_write = config_write.enable && (config_write.address == ADDR_CLEAR)
                               && config_write.data[CLEAR_FAULT_BIT];

    fault_low_after_reset: assert property (@(posedge clock) reset |=> !fault)
        else begin
            failure_count = failure_count + 1;
            $error("fault was high in the cycle after reset");
        end

    // Calibration is two stages deep, so every output needs a slow sample behind it
    output_has_source: assert property (@(posedge clock) disable iff (reset)
        sample_out.valid |-> $past(decimated.valid, 2))
        else begin
            failure_count = failure_count + 1;
            $error("sample_out.valid without a decimated sample two cycles earlier");
        end

    // The clear write becomes a pulse, and fault drops on the edge after that
    sticky_fault_hold: assert property (@(posedge clock) disable iff (reset)
        (STICKY_FAULT != 0) && $fell(fault) |-> $past(fault_clear_write, 2))
        else begin
            failure_count = failure_count + 1;
            $error("sticky fault fell without a clear write");
        end

endmodule

bind adc_processing adc_processing_sva #(
    .STICKY_FAULT(STICKY_FAULT)
) i_adc_processing_sva (
    .clock(clock),
    .reset(reset),
    .config_write(config_write),
    .sample_out(sample_out),
    .decimated(decimated),
    .fault(fault)
);

// File: verification/adc_processing_tb.sv
// Testbench for the ADC processing chain
// Directed tests, compare tasks, output monitor, reset and timeout
`timescale 1ns/1ns

module adc_processing_tb;

    import adc_types_pkg::*;
    import adc_config_pkg::*;

    localparam int MAX_DECIMATION_RATIO = 16;
    localparam int STICKY_FAULT         = 1;
    localparam int RESET_CYCLES         = 16;
    localparam int PIPELINE_LATENCY     = 3;
    localparam int OUTPUT_WAIT_CYCLES   = 20;
    localparam int QUIET_CYCLES         = 6;
    // All six tests need roughly 250 cycles, so this leaves a wide margin
    localparam int TIMEOUT_CYCLES       = 2000;

    logic           clock;
    logic           reset;
    sample_stream_t sample_in;
    reg_write_t     config_write;
    sample_stream_t sample_out;
    trip_flags_t    trip;
    logic           fault;

    integer seed = 32'hc905;
    int     cycle_count = 0;

    // Calibration settings as last written to the DUT
    sample_t cfg_offset;
    gain_t   cfg_gain;
    sample_t cfg_limit;
    logic    cfg_gain_enable;

    sample_t exp_data[$];
    int      exp_cycle[$];
    sample_t got_data[$];
    int      got_cycle[$];

    clock_gen #(.PERIOD(40)) i_clock_gen (.clock(clock));

    adc_processing #(
        .MAX_DECIMATION_RATIO(MAX_DECIMATION_RATIO),
        .STICKY_FAULT(STICKY_FAULT)
    ) i_adc_processing (
        .clock(clock),
        .reset(reset),
        .sample_in(sample_in),
        .config_write(config_write),
        .sample_out(sample_out),
        .trip(trip),
        .fault(fault)
    );

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "run stopped");
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("timeout: tests still running after %0d cycles",
                                     cycle_count));
        end
    end

    // A failed bound assertion ends the run
    always @(negedge clock) begin
        if (i_adc_processing.i_adc_processing_sva.failure_count != 0) begin
            report_failure("an assertion of the bound checker failed");
        end
    end

    // Every output sample is stored with the cycle in which it was valid
    always @(posedge clock) begin
        if (!reset && sample_out.valid) begin
            got_data.push_back(sample_out.data);
            got_cycle.push_back(cycle_count);
        end
    end

    task automatic compare_sample(input string name, input sample_t expected,
                                  input sample_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch at %0t ns: %s expected %0d, got %0d",
                                     $time, name, expected, actual));
        end
    endtask

    task automatic compare_trip(input string name, input trip_flags_t expected,
                                input trip_flags_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch at %0t ns: %s expected %b, got %b",
                                     $time, name, expected, actual));
        end
    endtask

    task automatic compare_fault(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch at %0t ns: %s expected %b, got %b",
                                     $time, name, expected, actual));
        end
    endtask

    task automatic compare_arrival(input string name, input int expected, input int actual);
        if (actual != expected) begin
            report_failure($sformatf("mismatch at %0t ns: %s expected cycle %0d, got %0d",
                                     $time, name, expected, actual));
        end
    endtask

    // Offset removal, Q4.12 gain, then clamp to the limit and the sample range
    function automatic sample_t calibrated_value(input sample_t raw);
        longint value;
        longint limit;
        value = longint'(raw) - longint'(cfg_offset);
        if (cfg_gain_enable) begin
            value = (value * longint'(cfg_gain)) >>> GAIN_FRACTION_BITS;
        end
        limit = longint'(cfg_limit);
        if (value > limit) begin
            value = limit;
        end else if (value < -limit) begin
            value = -limit;
        end
        if (value > 32767) begin
            value = 32767;
        end else if (value < -32768) begin
            value = -32768;
        end
        return sample_t'(value);
    endfunction

    // Tasks that drive are entered on a falling edge and return on the next one
    task automatic write_register(input reg_address_t addr, input sample_t value);
        config_write = '{enable: 1'b1, address: addr, data: value};
        @(negedge clock);
        config_write.enable = 1'b0;
    endtask

    task automatic drive_sample(input sample_t value, input logic expect_out);
        sample_in = '{data: value, valid: 1'b1};
        if (expect_out) begin
            exp_data.push_back(calibrated_value(value));
            exp_cycle.push_back(cycle_count + PIPELINE_LATENCY);
        end
        @(negedge clock);
        sample_in.valid = 1'b0;
    endtask

    task automatic set_calibration(input sample_t offset, input gain_t gain,
                                   input sample_t limit);
        write_register(ADDR_OFFSET, offset);
        write_register(ADDR_GAIN, gain);
        write_register(ADDR_LIMIT, limit);
        cfg_offset = offset;
        cfg_gain   = gain;
        cfg_limit  = limit;
    endtask

    task automatic set_control(input logic gain_enable, input logic fast_latching,
                               input logic slow_latching, input decimation_ratio_t ratio);
        sample_t word;
        word = '0;
        word[CTRL_GAIN_ENABLE_BIT]   = gain_enable;
        word[CTRL_FAST_LATCHING_BIT] = fast_latching;
        word[CTRL_SLOW_LATCHING_BIT] = slow_latching;
        word[CTRL_RATIO_LSB +: $bits(decimation_ratio_t)] = ratio;
        cfg_gain_enable = gain_enable;
        write_register(ADDR_CONTROL, word);
    endtask

    task automatic set_thresholds(input logic slow_side, input sample_t high_trip,
                                  input sample_t high_release, input sample_t low_trip,
                                  input sample_t low_release);
        reg_address_t base;
        base = slow_side ? ADDR_SLOW_HIGH_TRIP : ADDR_FAST_HIGH_TRIP;
        write_register(base, high_trip);
        write_register(base + 4'd1, high_release);
        write_register(base + 4'd2, low_trip);
        write_register(base + 4'd3, low_release);
    endtask

    // Waits for all expected outputs, then a few idle cycles to catch extra ones
    task automatic check_outputs(input string test_name);
        int waited;
        waited = 0;
        while (got_data.size() < exp_data.size()) begin
            if (waited >= OUTPUT_WAIT_CYCLES) begin
                report_failure($sformatf("%s: sample_out.valid never came for output %0d",
                                         test_name, got_data.size()));
            end
            @(negedge clock);
            waited++;
        end
        repeat (QUIET_CYCLES) @(negedge clock);
        if (got_data.size() != exp_data.size()) begin
            report_failure($sformatf("%s: %0d valid outputs on sample_out, expected %0d",
                                     test_name, got_data.size(), exp_data.size()));
        end
        foreach (exp_data[i]) begin
            compare_arrival($sformatf("sample_out.valid[%0d]", i), exp_cycle[i], got_cycle[i]);
            compare_sample($sformatf("sample_out.data[%0d]", i), exp_data[i], got_data[i]);
        end
        exp_data.delete();
        exp_cycle.delete();
        got_data.delete();
        got_cycle.delete();
    endtask

    task automatic test_pass_through();
        set_calibration(16'sd100, '0, SAMPLE_MAX);
        set_control(1'b0, 1'b0, 1'b0, 5'd1);
        repeat (20) begin
            drive_sample(sample_t'($random(seed)), 1'b1);
        end
        check_outputs("pass-through");
    endtask

    task automatic test_decimation();
        set_control(1'b0, 1'b0, 1'b0, 5'd4);
        for (int i = 1; i <= 16; i++) begin
            drive_sample(sample_t'($random(seed)), (i % 4) == 0);
        end
        check_outputs("decimation by 4");
        // Two samples into a group, then a new ratio must start a fresh group
        drive_sample(sample_t'($random(seed)), 1'b0);
        drive_sample(sample_t'($random(seed)), 1'b0);
        set_control(1'b0, 1'b0, 1'b0, 5'd3);
        for (int i = 1; i <= 6; i++) begin
            drive_sample(sample_t'($random(seed)), (i % 3) == 0);
        end
        check_outputs("ratio change");
    endtask

    task automatic test_gain_clamp();
        sample_t edge_values [0:8];
        edge_values = '{16'sd0, 16'sd600, 16'sd601, 16'sd300, -16'sd400, -16'sd401,
                        -16'sd1000, SAMPLE_MAX, SAMPLE_MIN};
        set_calibration(16'sd100, 16'sh2000, 16'sd1000);
        set_control(1'b1, 1'b0, 1'b0, 5'd1);
        foreach (edge_values[i]) begin
            drive_sample(edge_values[i], 1'b1);
        end
        repeat (6) begin
            drive_sample(sample_t'($random(seed) % 1200), 1'b1);
        end
        check_outputs("gain and clamp");
    endtask

    task automatic drive_and_check_trip(input sample_t value, input trip_flags_t expected);
        drive_sample(value, 1'b1);
        compare_trip("trip", expected, trip);
    endtask

    // Trip bits from the top are fast_high, fast_low, slow_high, slow_low
    task automatic test_fast_hysteresis();
        set_control(1'b0, 1'b0, 1'b0, 5'd1);
        set_thresholds(1'b0, 16'sd1000, 16'sd500, -16'sd1000, -16'sd500);
        compare_trip("trip", '0, trip);
        drive_and_check_trip(16'sd1200, trip_flags_t'(4'b1000));
        drive_and_check_trip(16'sd700, trip_flags_t'(4'b1000));
        drive_and_check_trip(16'sd400, trip_flags_t'(4'b0000));
        drive_and_check_trip(-16'sd1200, trip_flags_t'(4'b0100));
        drive_and_check_trip(-16'sd700, trip_flags_t'(4'b0100));
        drive_and_check_trip(-16'sd400, trip_flags_t'(4'b0000));
        check_outputs("fast hysteresis");
    endtask

    task automatic test_latching_fault();
        set_thresholds(1'b0, SAMPLE_MAX, SAMPLE_MAX, SAMPLE_MIN, SAMPLE_MIN);
        set_thresholds(1'b1, 16'sd2000, 16'sd1500, SAMPLE_MIN, SAMPLE_MIN);
        set_control(1'b0, 1'b0, 1'b1, 5'd1);
        write_register(ADDR_CLEAR, 16'h0007);
        @(negedge clock);
        compare_trip("trip", '0, trip);
        compare_fault("fault", 1'b0, fault);
        drive_sample(16'sd2500, 1'b1);
        compare_trip("trip", '0, trip);
        @(negedge clock);
        compare_trip("trip", trip_flags_t'(4'b0010), trip);
        compare_fault("fault", 1'b0, fault);
        @(negedge clock);
        compare_fault("fault", 1'b1, fault);
        drive_sample(16'sd1000, 1'b1);
        drive_sample(-16'sd3000, 1'b1);
        repeat (3) @(negedge clock);
        compare_trip("trip", trip_flags_t'(4'b0010), trip);
        compare_fault("fault", 1'b1, fault);
        write_register(ADDR_CLEAR, 16'h0006);
        @(negedge clock);
        compare_trip("trip", '0, trip);
        compare_fault("fault", 1'b0, fault);
        @(negedge clock);
        compare_fault("fault", 1'b0, fault);
        check_outputs("latching and sticky fault");
    endtask

    task automatic test_flush();
        set_control(1'b0, 1'b0, 1'b0, 5'd1);
        drive_sample(sample_t'($random(seed)), 1'b0);
        // The flush pulse lands as the first sample reaches the output stage
        // and the second one would enter stage 1
        sample_in    = '{data: sample_t'($random(seed)), valid: 1'b1};
        config_write = '{enable: 1'b1, address: ADDR_FLUSH, data: '0};
        @(negedge clock);
        sample_in.valid     = 1'b0;
        config_write.enable = 1'b0;
        check_outputs("flush");
        drive_sample(sample_t'($random(seed)), 1'b1);
        check_outputs("sample after flush");
    endtask

    initial begin
        reset           = 1'b1;
        sample_in       = '0;
        config_write    = '0;
        cfg_offset      = '0;
        cfg_gain        = '0;
        cfg_limit       = '0;
        cfg_gain_enable = 1'b0;
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        compare_trip("trip", '0, trip);
        compare_fault("fault", 1'b0, fault);
        // Both comparators stay quiet until a test arms them
        set_thresholds(1'b0, SAMPLE_MAX, SAMPLE_MAX, SAMPLE_MIN, SAMPLE_MIN);
        set_thresholds(1'b1, SAMPLE_MAX, SAMPLE_MAX, SAMPLE_MIN, SAMPLE_MIN);
        test_pass_through();
        test_decimation();
        test_gain_clamp();
        test_fast_hysteresis();
        test_latching_fault();
        test_flush();
        if (i_adc_processing.i_adc_processing_sva.failure_count != 0) begin
            report_failure("an assertion of the bound checker failed");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

// File: verification/clock_gen.sv
// Free-running testbench clock, low at time zero
`timescale 1ns/1ns

module clock_gen #(
    parameter int PERIOD = 40
) (
    output logic clock
);

    initial begin
        clock = 1'b0;
        forever begin
            #(PERIOD / 2) clock = ~clock;
        end
    end

endmodule
